// File: hdl/mci_lite_consts.svh
// Bus widths, register byte offsets and reset values
// shared by the MCI register block

`ifndef MCI_LITE_CONSTS_SVH
`define MCI_LITE_CONSTS_SVH

// Bus widths
`define MCI_DATA_W 32
`define MCI_ADDR_W 8
`define MCI_USER_W 32

////////////////////
// Register map
////////////////////

// Generic outputs and error masks
`define MCI_GENERIC_OUT_OFS   8'h00
`define MCI_FATAL_MASK_OFS    8'h04
`define MCI_NONFATAL_MASK_OFS 8'h08

// Sticky error status, write one to clear
`define MCI_FATAL_STS_OFS     8'h0C
`define MCI_NONFATAL_STS_OFS  8'h10

// Watchdog
`define MCI_WDT_EN_OFS        8'h14
`define MCI_WDT_CTRL_OFS      8'h18
`define MCI_WDT_T1_PERIOD_OFS 8'h1C
`define MCI_WDT_T2_PERIOD_OFS 8'h20
`define MCI_WDT_STS_OFS       8'h24

// Both timer periods come up at their maximum
`define MCI_WDT_PERIOD_RST {`MCI_DATA_W{1'b1}}

`endif

// File: hdl/mci_lite_pkg.sv
// Register select enumeration and watchdog status struct

package mci_lite_pkg;

    // One entry per mapped register
    typedef enum logic [3:0] {
        MCI_REG_GENERIC_OUT   = 4'd0,
        MCI_REG_FATAL_MASK    = 4'd1,
        MCI_REG_NONFATAL_MASK = 4'd2,
        MCI_REG_FATAL_STS     = 4'd3,
        MCI_REG_NONFATAL_STS  = 4'd4,
        MCI_REG_WDT_EN        = 4'd5,
        MCI_REG_WDT_CTRL      = 4'd6,
        MCI_REG_WDT_T1_PERIOD = 4'd7,
        MCI_REG_WDT_T2_PERIOD = 4'd8,
        MCI_REG_WDT_STS       = 4'd9,
        // Unmapped or misaligned address
        MCI_REG_NONE          = 4'd15
    } mci_reg_e;

    // Layout matches the WDT_STS register, t1 in bit 0
    typedef struct packed {
        logic t2_timeout;
        logic t1_timeout;
    } mci_wdt_sts_t;

endpackage

// File: hdl/mci_lite_if.sv
// Request/response interface between the decode, execute and result stages
// Error and watchdog status interface from execute to result

`timescale 1ns/1ps

`include "mci_lite_consts.svh"

interface mci_req_if;

    // Decoded request
    logic                   valid;
    logic                   write;
    mci_lite_pkg::mci_reg_e reg_sel;
    logic [`MCI_DATA_W-1:0] wdata;
    logic                   priv;
    logic                   addr_err;

    // Response from the register bank
    logic                   rsp_valid;
    logic [`MCI_DATA_W-1:0] rsp_rdata;
    logic                   rsp_error;

    modport decode (
        output valid, write, reg_sel, wdata, priv, addr_err
    );

    modport execute (
        input  valid, write, reg_sel, wdata, priv, addr_err,
        output rsp_valid, rsp_rdata, rsp_error
    );

    modport result (
        input rsp_valid, rsp_rdata, rsp_error
    );

endinterface

interface mci_err_if;

    logic [`MCI_DATA_W-1:0]     fatal_sts;
    logic [`MCI_DATA_W-1:0]     fatal_mask;
    logic [`MCI_DATA_W-1:0]     nonfatal_sts;
    logic [`MCI_DATA_W-1:0]     nonfatal_mask;
    mci_lite_pkg::mci_wdt_sts_t wdt_sts;

    modport execute (
        output fatal_sts, fatal_mask, nonfatal_sts, nonfatal_mask, wdt_sts
    );

    modport result (
        input fatal_sts, fatal_mask, nonfatal_sts, nonfatal_mask, wdt_sts
    );

endinterface

// File: hdl/mci_lite_decode.sv
// Request decode stage with the address map and the SoC-config privilege check

`timescale 1ns/1ps

`include "mci_lite_consts.svh"

module mci_lite_decode (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   req_valid_i,
    input  logic                   req_write_i,
    input  logic [`MCI_ADDR_W-1:0] req_addr_i,
    input  logic [`MCI_DATA_W-1:0] req_wdata_i,
    input  logic [`MCI_USER_W-1:0] req_user_i,
    input  logic [`MCI_USER_W-1:0] strap_soc_config_user_i,
    mci_req_if.decode              req_o
);

    mci_lite_pkg::mci_reg_e reg_sel_d;
    logic                   addr_err_d;

    // Address map, any address off a word boundary misses every entry
    always_comb begin
        case (req_addr_i)
            `MCI_GENERIC_OUT_OFS:   reg_sel_d = mci_lite_pkg::MCI_REG_GENERIC_OUT;
            `MCI_FATAL_MASK_OFS:    reg_sel_d = mci_lite_pkg::MCI_REG_FATAL_MASK;
            `MCI_NONFATAL_MASK_OFS: reg_sel_d = mci_lite_pkg::MCI_REG_NONFATAL_MASK;
            `MCI_FATAL_STS_OFS:     reg_sel_d = mci_lite_pkg::MCI_REG_FATAL_STS;
            `MCI_NONFATAL_STS_OFS:  reg_sel_d = mci_lite_pkg::MCI_REG_NONFATAL_STS;
            `MCI_WDT_EN_OFS:        reg_sel_d = mci_lite_pkg::MCI_REG_WDT_EN;
            `MCI_WDT_CTRL_OFS:      reg_sel_d = mci_lite_pkg::MCI_REG_WDT_CTRL;
            `MCI_WDT_T1_PERIOD_OFS: reg_sel_d = mci_lite_pkg::MCI_REG_WDT_T1_PERIOD;
            `MCI_WDT_T2_PERIOD_OFS: reg_sel_d = mci_lite_pkg::MCI_REG_WDT_T2_PERIOD;
            `MCI_WDT_STS_OFS:       reg_sel_d = mci_lite_pkg::MCI_REG_WDT_STS;
            default:                reg_sel_d = mci_lite_pkg::MCI_REG_NONE;
        endcase
    end

    assign addr_err_d = (req_addr_i[1:0] != 2'b00) ||
                        (reg_sel_d == mci_lite_pkg::MCI_REG_NONE);

    // Request strobe
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            req_o.valid <= 1'b0;
        end else begin
            req_o.valid <= req_valid_i;
        end
    end

    // Request payload, qualified by valid downstream
    always_ff @(posedge clk) begin
        req_o.write    <= req_write_i;
        req_o.reg_sel  <= reg_sel_d;
        req_o.wdata    <= req_wdata_i;
        req_o.priv     <= (req_user_i == strap_soc_config_user_i);
        req_o.addr_err <= addr_err_d;
    end

    // A rejected address never selects a register in the bank
    a_addr_err_no_sel: assert property (@(posedge clk) disable iff (!rst_n_i)
        (req_o.valid && req_o.addr_err) |-> (req_o.reg_sel == mci_lite_pkg::MCI_REG_NONE));

endmodule

// File: hdl/mci_lite_wdt.sv
// Cascaded two-stage watchdog
// Timer 2 runs only while a timer 1 timeout is left unserviced

`timescale 1ns/1ps

`include "mci_lite_consts.svh"

module mci_lite_wdt (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       timer_en_i,
    input  logic                       restart_i,
    input  logic                       t1_serviced_i,
    input  logic                       t2_serviced_i,
    input  logic [`MCI_DATA_W-1:0]     t1_period_i,
    input  logic [`MCI_DATA_W-1:0]     t2_period_i,
    output mci_lite_pkg::mci_wdt_sts_t wdt_sts_o
);

    logic [`MCI_DATA_W-1:0] t1_cnt;
    logic [`MCI_DATA_W-1:0] t2_cnt;
    logic                   clear;

    // Restart and either service pulse rewind the whole cascade
    assign clear = restart_i || t1_serviced_i || t2_serviced_i;

    ////////////////////
    // Timer 1
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            t1_cnt               <= '0;
            wdt_sts_o.t1_timeout <= 1'b0;
        end else if (clear) begin
            t1_cnt               <= '0;
            wdt_sts_o.t1_timeout <= 1'b0;
        end else if (timer_en_i && !wdt_sts_o.t1_timeout) begin
            if (t1_cnt == t1_period_i) begin
                // Stops here until serviced
                wdt_sts_o.t1_timeout <= 1'b1;
            end else begin
                t1_cnt <= t1_cnt + 1'b1;
            end
        end
    end

    ////////////////////
    // Timer 2
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            t2_cnt               <= '0;
            wdt_sts_o.t2_timeout <= 1'b0;
        end else if (clear) begin
            t2_cnt <= '0;
        end else if (timer_en_i && wdt_sts_o.t1_timeout && !wdt_sts_o.t2_timeout) begin
            if (t2_cnt == t2_period_i) begin
                // Fatal, held until reset
                wdt_sts_o.t2_timeout <= 1'b1;
            end else begin
                t2_cnt <= t2_cnt + 1'b1;
            end
        end
    end

endmodule

// File: hdl/mci_lite_execute.sv
// Register bank with sticky error status and the read mux
// Holds the watchdog instance and drives the response fields

`timescale 1ns/1ps

`include "mci_lite_consts.svh"

module mci_lite_execute (
    input  logic                   clk,
    input  logic                   rst_n_i,
    mci_req_if.execute             req_i,
    input  logic [`MCI_DATA_W-1:0] agg_error_fatal_i,
    input  logic [`MCI_DATA_W-1:0] agg_error_non_fatal_i,
    output logic [`MCI_DATA_W-1:0] generic_output_wires_o,
    mci_err_if.execute             err_o
);

    logic [`MCI_DATA_W-1:0]     generic_out_q;
    logic [`MCI_DATA_W-1:0]     fatal_mask_q;
    logic [`MCI_DATA_W-1:0]     nonfatal_mask_q;
    logic [`MCI_DATA_W-1:0]     fatal_sts_q;
    logic [`MCI_DATA_W-1:0]     nonfatal_sts_q;
    logic [`MCI_DATA_W-1:0]     t1_period_q;
    logic [`MCI_DATA_W-1:0]     t2_period_q;
    logic                       wdt_en_q;
    logic [`MCI_DATA_W-1:0]     fatal_clr;
    logic [`MCI_DATA_W-1:0]     nonfatal_clr;
    logic [`MCI_DATA_W-1:0]     rdata_d;
    logic                       wr_ok;
    logic                       wdt_restart;
    logic                       t1_serviced;
    logic                       t2_serviced;
    mci_lite_pkg::mci_wdt_sts_t wdt_sts;

    // Only the strap user may change state
    assign wr_ok = req_i.valid && req_i.write && req_i.priv && !req_i.addr_err;

    ////////////////////
    // Register bank
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            generic_out_q   <= '0;
            fatal_mask_q    <= '0;
            nonfatal_mask_q <= '0;
            wdt_en_q        <= 1'b0;
            t1_period_q     <= `MCI_WDT_PERIOD_RST;
            t2_period_q     <= `MCI_WDT_PERIOD_RST;
        end else if (wr_ok) begin
            case (req_i.reg_sel)
                mci_lite_pkg::MCI_REG_GENERIC_OUT:   generic_out_q   <= req_i.wdata;
                mci_lite_pkg::MCI_REG_FATAL_MASK:    fatal_mask_q    <= req_i.wdata;
                mci_lite_pkg::MCI_REG_NONFATAL_MASK: nonfatal_mask_q <= req_i.wdata;
                mci_lite_pkg::MCI_REG_WDT_EN:        wdt_en_q        <= req_i.wdata[0];
                mci_lite_pkg::MCI_REG_WDT_T1_PERIOD: t1_period_q     <= req_i.wdata;
                mci_lite_pkg::MCI_REG_WDT_T2_PERIOD: t2_period_q     <= req_i.wdata;
                default: ;
            endcase
        end
    end

    // Write-one-to-clear masks for the sticky status
    assign fatal_clr = (wr_ok && req_i.reg_sel == mci_lite_pkg::MCI_REG_FATAL_STS) ?
                       req_i.wdata : '0;
    assign nonfatal_clr = (wr_ok && req_i.reg_sel == mci_lite_pkg::MCI_REG_NONFATAL_STS) ?
                          req_i.wdata : '0;

    // A new error in the same cycle wins over the clear
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            fatal_sts_q    <= '0;
            nonfatal_sts_q <= '0;
        end else begin
            fatal_sts_q    <= (fatal_sts_q & ~fatal_clr) | agg_error_fatal_i;
            nonfatal_sts_q <= (nonfatal_sts_q & ~nonfatal_clr) | agg_error_non_fatal_i;
        end
    end

    ////////////////////
    // Watchdog
    ////////////////////

    // Control and status writes act as single-cycle pulses
    assign wdt_restart = wr_ok && (req_i.reg_sel == mci_lite_pkg::MCI_REG_WDT_CTRL) &&
                         req_i.wdata[0];
    assign t1_serviced = wr_ok && (req_i.reg_sel == mci_lite_pkg::MCI_REG_WDT_STS) &&
                         req_i.wdata[0];
    assign t2_serviced = wr_ok && (req_i.reg_sel == mci_lite_pkg::MCI_REG_WDT_STS) &&
                         req_i.wdata[1];

    mci_lite_wdt u_wdt (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .timer_en_i    (wdt_en_q),
        .restart_i     (wdt_restart),
        .t1_serviced_i (t1_serviced),
        .t2_serviced_i (t2_serviced),
        .t1_period_i   (t1_period_q),
        .t2_period_i   (t2_period_q),
        .wdt_sts_o     (wdt_sts)
    );

    ////////////////////
    // Read path
    ////////////////////

    always_comb begin
        rdata_d = '0;
        case (req_i.reg_sel)
            mci_lite_pkg::MCI_REG_GENERIC_OUT:   rdata_d = generic_out_q;
            mci_lite_pkg::MCI_REG_FATAL_MASK:    rdata_d = fatal_mask_q;
            mci_lite_pkg::MCI_REG_NONFATAL_MASK: rdata_d = nonfatal_mask_q;
            mci_lite_pkg::MCI_REG_FATAL_STS:     rdata_d = fatal_sts_q;
            mci_lite_pkg::MCI_REG_NONFATAL_STS:  rdata_d = nonfatal_sts_q;
            mci_lite_pkg::MCI_REG_WDT_EN:        rdata_d[0] = wdt_en_q;
            mci_lite_pkg::MCI_REG_WDT_T1_PERIOD: rdata_d = t1_period_q;
            mci_lite_pkg::MCI_REG_WDT_T2_PERIOD: rdata_d = t2_period_q;
            mci_lite_pkg::MCI_REG_WDT_STS:       rdata_d[1:0] = wdt_sts;
            // WDT_CTRL is write-only and reads as zero
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            req_i.rsp_valid <= 1'b0;
            req_i.rsp_error <= 1'b0;
        end else begin
            req_i.rsp_valid <= req_i.valid;
            req_i.rsp_error <= req_i.valid &&
                               (req_i.addr_err || (req_i.write && !req_i.priv));
        end
    end

    // Write responses and failed reads carry zero data
    always_ff @(posedge clk) begin
        req_i.rsp_rdata <= (req_i.valid && !req_i.write && !req_i.addr_err) ? rdata_d : '0;
    end

    assign generic_output_wires_o = generic_out_q;

    assign err_o.fatal_sts     = fatal_sts_q;
    assign err_o.fatal_mask    = fatal_mask_q;
    assign err_o.nonfatal_sts  = nonfatal_sts_q;
    assign err_o.nonfatal_mask = nonfatal_mask_q;
    assign err_o.wdt_sts       = wdt_sts;

    // One response per decoded request, one cycle behind, no stalls
    a_rsp_follows_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_i.rsp_valid == $past(req_i.valid));

endmodule

// File: hdl/mci_lite_result.sv
// Response output register, error aggregation and interrupt outputs

`timescale 1ns/1ps

`include "mci_lite_consts.svh"

module mci_lite_result (
    input  logic                   clk,
    input  logic                   rst_n_i,
    mci_req_if.result              rsp_i,
    mci_err_if.result              err_i,
    output logic                   rsp_valid_o,
    output logic [`MCI_DATA_W-1:0] rsp_rdata_o,
    output logic                   rsp_error_o,
    output logic                   all_error_fatal_o,
    output logic                   all_error_non_fatal_o,
    output logic                   mci_intr_o,
    output logic                   nmi_intr_o
);

    // Response and interrupt flags
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rsp_valid_o           <= 1'b0;
            rsp_error_o           <= 1'b0;
            all_error_fatal_o     <= 1'b0;
            all_error_non_fatal_o <= 1'b0;
            mci_intr_o            <= 1'b0;
            nmi_intr_o            <= 1'b0;
        end else begin
            rsp_valid_o           <= rsp_i.rsp_valid;
            rsp_error_o           <= rsp_i.rsp_error;
            // Any unmasked sticky bit raises the aggregate
            all_error_fatal_o     <= |(err_i.fatal_sts & ~err_i.fatal_mask);
            all_error_non_fatal_o <= |(err_i.nonfatal_sts & ~err_i.nonfatal_mask);
            mci_intr_o            <= err_i.wdt_sts.t1_timeout;
            nmi_intr_o            <= err_i.wdt_sts.t2_timeout;
        end
    end

    // Read data
    always_ff @(posedge clk) begin
        rsp_rdata_o <= rsp_i.rsp_rdata;
    end

endmodule

// File: hdl/mci_lite_top.sv
// Top level of the MCI register block
// Decode, execute and result stages joined by the request and error interfaces

`timescale 1ns/1ps

`include "mci_lite_consts.svh"

module mci_lite_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   req_valid_i,
    input  logic                   req_write_i,
    input  logic [`MCI_ADDR_W-1:0] req_addr_i,
    input  logic [`MCI_DATA_W-1:0] req_wdata_i,
    input  logic [`MCI_USER_W-1:0] req_user_i,
    input  logic [`MCI_USER_W-1:0] strap_soc_config_user_i,
    input  logic [`MCI_DATA_W-1:0] agg_error_fatal_i,
    input  logic [`MCI_DATA_W-1:0] agg_error_non_fatal_i,
    output logic                   rsp_valid_o,
    output logic [`MCI_DATA_W-1:0] rsp_rdata_o,
    output logic                   rsp_error_o,
    output logic [`MCI_DATA_W-1:0] generic_output_wires_o,
    output logic                   all_error_fatal_o,
    output logic                   all_error_non_fatal_o,
    output logic                   mci_intr_o,
    output logic                   nmi_intr_o
);

    mci_req_if u_req_if ();
    mci_err_if u_err_if ();

    mci_lite_decode u_decode (
        .clk                     (clk),
        .rst_n_i                 (rst_n_i),
        .req_valid_i             (req_valid_i),
        .req_write_i             (req_write_i),
        .req_addr_i              (req_addr_i),
        .req_wdata_i             (req_wdata_i),
        .req_user_i              (req_user_i),
        .strap_soc_config_user_i (strap_soc_config_user_i),
        .req_o                   (u_req_if.decode)
    );

    mci_lite_execute u_execute (
        .clk                    (clk),
        .rst_n_i                (rst_n_i),
        .req_i                  (u_req_if.execute),
        .agg_error_fatal_i      (agg_error_fatal_i),
        .agg_error_non_fatal_i  (agg_error_non_fatal_i),
        .generic_output_wires_o (generic_output_wires_o),
        .err_o                  (u_err_if.execute)
    );

    mci_lite_result u_result (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .rsp_i                 (u_req_if.result),
        .err_i                 (u_err_if.result),
        .rsp_valid_o           (rsp_valid_o),
        .rsp_rdata_o           (rsp_rdata_o),
        .rsp_error_o           (rsp_error_o),
        .all_error_fatal_o     (all_error_fatal_o),
        .all_error_non_fatal_o (all_error_non_fatal_o),
        .mci_intr_o            (mci_intr_o),
        .nmi_intr_o            (nmi_intr_o)
    );

endmodule

// File: tests/mci_lite_tb.sv
// Self-checking testbench for the MCI register block
// Stimulus table with queued expectations, LFSR write data,
// error aggregation and watchdog timing checks

`timescale 1ns/1ps

`include "mci_lite_consts.svh"

module mci_lite_tb;

    localparam logic [`MCI_USER_W-1:0] STRAP_USER = 32'h1000_0042;
    localparam logic [`MCI_USER_W-1:0] OTHER_USER = 32'h2000_0007;
    localparam logic [`MCI_DATA_W-1:0] LO_BIT     = 32'h0000_0010;
    localparam logic [`MCI_DATA_W-1:0] HI_BIT     = 32'h0000_0100;
    localparam int T1_PERIOD   = 20;
    localparam int T2_PERIOD   = 10;
    localparam int TABLE_LEN   = 36;
    localparam int CYCLE_LIMIT = 16 + 4 * (TABLE_LEN + T1_PERIOD + T2_PERIOD) + 200;

    typedef struct packed {
        logic                   write;
        logic [`MCI_ADDR_W-1:0] addr;
        logic [`MCI_DATA_W-1:0] wdata;
        logic [`MCI_USER_W-1:0] user;
        logic [`MCI_DATA_W-1:0] exp_rdata;
        logic                   exp_error;
    } entry_t;

    logic                   clk;
    logic                   rst_n_i;
    logic                   req_valid_i;
    logic                   req_write_i;
    logic [`MCI_ADDR_W-1:0] req_addr_i;
    logic [`MCI_DATA_W-1:0] req_wdata_i;
    logic [`MCI_USER_W-1:0] req_user_i;
    logic [`MCI_USER_W-1:0] strap_soc_config_user_i;
    logic [`MCI_DATA_W-1:0] agg_error_fatal_i;
    logic [`MCI_DATA_W-1:0] agg_error_non_fatal_i;
    logic                   rsp_valid_o;
    logic [`MCI_DATA_W-1:0] rsp_rdata_o;
    logic                   rsp_error_o;
    logic [`MCI_DATA_W-1:0] generic_output_wires_o;
    logic                   all_error_fatal_o;
    logic                   all_error_non_fatal_o;
    logic                   mci_intr_o;
    logic                   nmi_intr_o;

    entry_t      table_q[$];
    entry_t      exp_q[$];
    int          due_q[$];
    int          cycle = 0;
    int          responses_seen = 0;
    logic [31:0] lfsr_state;

    mci_lite_top u_mci_lite_top (.*);

    always #20 clk = ~clk;

    ////////////////////
    // Failure reporting
    ////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("ERROR at %0t: %s", $time, msg));
    endtask

    task automatic check_rsp(input logic [`MCI_DATA_W-1:0] got_rdata,
                             input logic [`MCI_DATA_W-1:0] exp_rdata,
                             input logic got_error, input logic exp_error,
                             input string what);
        if (got_rdata !== exp_rdata || got_error !== exp_error) begin
            report_mismatch($sformatf("%s: data %h expected %h, error %b expected %b",
                                      what, got_rdata, exp_rdata, got_error, exp_error));
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    // Cycle counter with the run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > CYCLE_LIMIT) begin
            abort_run($sformatf("Timeout: cycle limit %0d reached before the tests ended",
                                CYCLE_LIMIT));
        end
    end

    ////////////////////
    // Stimulus helpers
    ////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_word(output logic [`MCI_DATA_W-1:0] w);
        for (int i = 0; i < `MCI_DATA_W; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[`MCI_DATA_W-2:0], lfsr_state[0]};
        end
    endtask

    task automatic add_entry(input logic is_write, input logic [`MCI_ADDR_W-1:0] addr,
                             input logic [`MCI_DATA_W-1:0] wdata,
                             input logic [`MCI_USER_W-1:0] user,
                             input logic [`MCI_DATA_W-1:0] exp_rdata,
                             input logic exp_error);
        entry_t e;
        e = '{is_write, addr, wdata, user, exp_rdata, exp_error};
        table_q.push_back(e);
    endtask

    // One entry per cycle and a wait for every response
    task automatic run_table();
        foreach (table_q[i]) begin
            @(posedge clk);
            req_valid_i <= 1'b1;
            req_write_i <= table_q[i].write;
            req_addr_i  <= table_q[i].addr;
            req_wdata_i <= table_q[i].wdata;
            req_user_i  <= table_q[i].user;
            exp_q.push_back(table_q[i]);
            // Sampled at the next edge with the response two edges later
            due_q.push_back(cycle + 4);
        end
        @(posedge clk);
        req_valid_i <= 1'b0;
        table_q.delete();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    task automatic pulse_errors(input logic is_fatal, input logic [`MCI_DATA_W-1:0] bits);
        @(posedge clk);
        if (is_fatal) begin
            agg_error_fatal_i <= bits;
        end else begin
            agg_error_non_fatal_i <= bits;
        end
        @(posedge clk);
        agg_error_fatal_i     <= '0;
        agg_error_non_fatal_i <= '0;
        // Aggregate output trails the status by one edge
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic check_agg(input logic is_fatal, input logic exp);
        if (is_fatal) begin
            check_level(all_error_fatal_o, exp, "all_error_fatal_o");
        end else begin
            check_level(all_error_non_fatal_o, exp, "all_error_non_fatal_o");
        end
    endtask

    task automatic wait_rise(input logic nmi, input int min_cycles, input int max_cycles);
        int n;
        n = 0;
        while ((nmi ? nmi_intr_o : mci_intr_o) !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > max_cycles) begin
                report_mismatch($sformatf("%s still low after %0d cycles",
                                          nmi ? "nmi_intr_o" : "mci_intr_o", n));
            end
        end
        if (n < min_cycles) begin
            report_mismatch($sformatf("%s rose after %0d cycles, expected at least %0d",
                                      nmi ? "nmi_intr_o" : "mci_intr_o", n, min_cycles));
        end
    endtask

    // Sticky status, mask and write-one-to-clear on one error path
    task automatic exercise_error_path(input logic is_fatal);
        logic [`MCI_ADDR_W-1:0] mask_ofs;
        logic [`MCI_ADDR_W-1:0] sts_ofs;
        mask_ofs = is_fatal ? `MCI_FATAL_MASK_OFS : `MCI_NONFATAL_MASK_OFS;
        sts_ofs  = is_fatal ? `MCI_FATAL_STS_OFS : `MCI_NONFATAL_STS_OFS;
        add_entry(1'b1, mask_ofs, '0, STRAP_USER, '0, 1'b0);
        run_table();
        check_agg(is_fatal, 1'b0);
        pulse_errors(is_fatal, LO_BIT | HI_BIT);
        check_agg(is_fatal, 1'b1);
        check_agg(!is_fatal, 1'b0);
        add_entry(1'b0, sts_ofs, '0, STRAP_USER, LO_BIT | HI_BIT, 1'b0);
        add_entry(1'b1, mask_ofs, LO_BIT | HI_BIT, STRAP_USER, '0, 1'b0);
        run_table();
        check_agg(is_fatal, 1'b0);
        add_entry(1'b1, mask_ofs, HI_BIT, STRAP_USER, '0, 1'b0);
        run_table();
        check_agg(is_fatal, 1'b1);
        // Clear the unmasked bit while the masked one stays
        add_entry(1'b1, sts_ofs, LO_BIT, STRAP_USER, '0, 1'b0);
        add_entry(1'b0, sts_ofs, '0, STRAP_USER, HI_BIT, 1'b0);
        run_table();
        check_agg(is_fatal, 1'b0);
        add_entry(1'b1, mask_ofs, '0, STRAP_USER, '0, 1'b0);
        run_table();
        check_agg(is_fatal, 1'b1);
        add_entry(1'b1, sts_ofs, HI_BIT, STRAP_USER, '0, 1'b0);
        add_entry(0, sts_ofs, '0, STRAP_USER, '0, 1'b0);
        run_table();
        check_agg(is_fatal, 1'b0);
    endtask

    // In-order response monitor with fixed latency
    always @(negedge clk) begin
        if (rst_n_i === 1'b1 && rsp_valid_o !== 1'b0) begin
            if (exp_q.size() == 0) begin
                abort_run("A response arrived with no request in flight");
            end
            if (cycle != due_q[0]) begin
                report_mismatch($sformatf("response in cycle %0d, expected in cycle %0d",
                                          cycle, due_q[0]));
            end
            check_rsp(rsp_rdata_o, exp_q[0].exp_rdata, rsp_error_o, exp_q[0].exp_error,
                      $sformatf("response to addr %h", exp_q[0].addr));
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
            responses_seen++;
        end
    end

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        logic [`MCI_DATA_W-1:0] d0;
        logic [`MCI_DATA_W-1:0] d1;
        logic [`MCI_DATA_W-1:0] d2;
        logic [`MCI_DATA_W-1:0] d3;
        clk                     = 1'b0;
        rst_n_i                 = 1'b0;
        req_valid_i             = 1'b0;
        req_write_i             = 1'b0;
        req_addr_i              = '0;
        req_wdata_i             = '0;
        req_user_i              = '0;
        strap_soc_config_user_i = STRAP_USER;
        agg_error_fatal_i       = '0;
        agg_error_non_fatal_i   = '0;
        lfsr_state              = 32'hac72_374d;
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_level(rsp_valid_o, 1'b0, "rsp_valid_o after reset");
        check_level(all_error_fatal_o | all_error_non_fatal_o, 1'b0, "all_error after reset");
        check_level(mci_intr_o | nmi_intr_o, 1'b0, "interrupts after reset");
        check_rsp(generic_output_wires_o, '0, rsp_error_o, 1'b0, "outputs after reset");

        // Back-to-back privileged writes and read-back
        rand_word(d0);
        rand_word(d1);
        rand_word(d2);
        add_entry(1'b1, `MCI_GENERIC_OUT_OFS, d0, STRAP_USER, '0, 1'b0);
        add_entry(1'b1, `MCI_FATAL_MASK_OFS, d1, STRAP_USER, '0, 1'b0);
        add_entry(1'b1, `MCI_NONFATAL_MASK_OFS, d2, STRAP_USER, '0, 1'b0);
        add_entry(1'b0, `MCI_GENERIC_OUT_OFS, '0, STRAP_USER, d0, 1'b0);
        add_entry(1'b0, `MCI_FATAL_MASK_OFS, '0, STRAP_USER, d1, 1'b0);
        add_entry(1'b0, `MCI_NONFATAL_MASK_OFS, '0, STRAP_USER, d2, 1'b0);
        run_table();
        check_rsp(generic_output_wires_o, d0, 1'b0, 1'b0, "generic_output_wires_o");

        // Unprivileged writes and bad addresses
        rand_word(d3);
        add_entry(1'b1, `MCI_GENERIC_OUT_OFS, d3, OTHER_USER, '0, 1'b1);
        add_entry(1'b0, `MCI_GENERIC_OUT_OFS, '0, OTHER_USER, d0, 1'b0);
        add_entry(1'b0, 8'h28, '0, STRAP_USER, '0, 1'b1);
        add_entry(1'b0, 8'h05, '0, STRAP_USER, '0, 1'b1);
        add_entry(1'b1, 8'h3C, d3, STRAP_USER, '0, 1'b1);
        run_table();
        check_rsp(generic_output_wires_o, d0, 1'b0, 1'b0, "generic_output_wires_o kept");

        exercise_error_path(1'b1);
        exercise_error_path(1'b0);

        // Watchdog timer 1 timeout and service
        add_entry(1'b1, `MCI_WDT_T2_PERIOD_OFS, T2_PERIOD, STRAP_USER, '0, 1'b0);
        add_entry(1'b1, `MCI_WDT_T1_PERIOD_OFS, T1_PERIOD, STRAP_USER, '0, 1'b0);
        add_entry(1'b1, `MCI_WDT_EN_OFS, 32'h1, STRAP_USER, '0, 1'b0);
        run_table();
        wait_rise(1'b0, T1_PERIOD, T1_PERIOD + 8);
        check_level(nmi_intr_o, 1'b0, "nmi_intr_o at timer 1 timeout");
        add_entry(1'b1, `MCI_WDT_STS_OFS, 32'h1, STRAP_USER, '0, 1'b0);
        run_table();
        check_level(mci_intr_o, 1'b0, "mci_intr_o after service");

        // Restart part way into the period
        repeat (12) begin
            @(negedge clk);
            check_level(mci_intr_o, 1'b0, "mci_intr_o before restart");
        end
        add_entry(1'b1, `MCI_WDT_CTRL_OFS, 32'h1, STRAP_USER, '0, 1'b0);
        run_table();
        wait_rise(1'b0, T1_PERIOD, T1_PERIOD + 8);
        check_level(nmi_intr_o, 1'b0, "nmi_intr_o after restart");

        // Timer 1 left unserviced escalates to the NMI
        wait_rise(1'b1, T2_PERIOD, T2_PERIOD + 8);
        repeat (4) begin
            @(negedge clk);
            check_level(mci_intr_o & nmi_intr_o, 1'b1, "both interrupts held");
        end
        add_entry(1'b1, `MCI_WDT_STS_OFS, 32'h3, STRAP_USER, '0, 1'b0);
        add_entry(1'b0, `MCI_WDT_STS_OFS, '0, STRAP_USER, 32'h2, 1'b0);
        run_table();
        check_level(mci_intr_o, 1'b0, "mci_intr_o after service");
        check_level(nmi_intr_o, 1'b1, "nmi_intr_o held until reset");

        if (responses_seen == TABLE_LEN) begin
            $display("Simulation passed");
            $finish;
        end else begin
            abort_run($sformatf("Only %0d of %0d responses were seen",
                                responses_seen, TABLE_LEN));
        end
    end

endmodule

// File: mci_lite_top.f
+incdir+hdl
hdl/mci_lite_pkg.sv
hdl/mci_lite_if.sv
hdl/mci_lite_decode.sv
hdl/mci_lite_wdt.sv
hdl/mci_lite_execute.sv
hdl/mci_lite_result.sv
hdl/mci_lite_top.sv
tests/mci_lite_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the MCI register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f mci_lite_top.f --top-module mci_lite_tb \
    -Mdir obj_dir -o mci_lite_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build failed"
    exit 1
fi

./obj_dir/mci_lite_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -qx "Simulation passed" "$SIM_LOG" && [ $sim_status -eq 0 ]; then
    exit 0
fi
echo "Simulator exit status $sim_status"
exit 1
